// File: eth_rx_top.f
hw/gmii_pkg.sv
hw/rx_pkg.sv
hw/gmii_frame_parser.sv
hw/rx_crc32.sv
hw/rx_byte_counter.sv
hw/rx_capture_fsm.sv
hw/eth_rx_top.sv
testbench/eth_rx_checker.sv
testbench/tb_eth_rx_top.sv

// File: hw/eth_rx_top.sv
`timescale 1ns/1ps

module eth_rx_top
    import gmii_pkg::*;
    import rx_pkg::*;
(
    input  logic  gmii_rxc,
    input  logic  rst,
    input  byte_t gmii_rxd_i,
    input  logic  gmii_rx_dv_i,
    input  logic  gmii_rx_er_i,
    input  addr_t rx_addr_i,
    input  logic  rx_ready_i,
    output byte_t rx_data_o,
    output addr_t rx_addr_o,
    output logic  rx_valid_o,
    output len_t  rx_len_o,
    output logic  rx_crc_ok_o,
    output logic  rx_err_o,
    output logic  rx_done_o
);

    logic  byte_valid;
    byte_t byte_data;
    logic  frame_start;
    logic  frame_end;
    logic  in_frame;
    logic  frame_err;
    logic  load_base;
    logic  capture_en;     // per byte, only while receiving

    gmii_frame_parser u_parser (
        .gmii_rxc      (gmii_rxc),
        .rst           (rst),
        .gmii_rxd_i    (gmii_rxd_i),
        .gmii_rx_dv_i  (gmii_rx_dv_i),
        .gmii_rx_er_i  (gmii_rx_er_i),
        .byte_valid_o  (byte_valid),
        .byte_data_o   (byte_data),
        .frame_start_o (frame_start),
        .frame_end_o   (frame_end),
        .in_frame_o    (in_frame),
        .frame_err_o   (frame_err)
    );

    rx_crc32 u_crc (
        .gmii_rxc (gmii_rxc),
        .rst      (rst),
        .init_i   (load_base),
        .en_i     (capture_en),
        .data_i   (byte_data),
        .crc_ok_o (rx_crc_ok_o)
    );

    rx_byte_counter u_counter (
        .gmii_rxc    (gmii_rxc),
        .rst         (rst),
        .load_i      (load_base),
        .inc_i       (capture_en),
        .base_addr_i (rx_addr_i),
        .addr_o      (rx_addr_o),
        .len_o       (rx_len_o)
    );

    rx_capture_fsm u_fsm (
        .gmii_rxc      (gmii_rxc),
        .rst           (rst),
        .rx_ready_i    (rx_ready_i),
        .in_frame_i    (in_frame),
        .frame_start_i (frame_start),
        .frame_end_i   (frame_end),
        .frame_err_i   (frame_err),
        .byte_valid_i  (byte_valid),
        .byte_data_i   (byte_data),
        .load_base_o   (load_base),
        .capture_en_o  (capture_en),
        .rx_valid_o    (rx_valid_o),
        .rx_data_o     (rx_data_o),
        .rx_done_o     (rx_done_o),
        .rx_err_o      (rx_err_o)
    );

endmodule

// File: hw/gmii_frame_parser.sv
`timescale 1ns/1ps

module gmii_frame_parser import gmii_pkg::*; (
    input  logic  gmii_rxc,
    input  logic  rst,
    input  byte_t gmii_rxd_i,
    input  logic  gmii_rx_dv_i,
    input  logic  gmii_rx_er_i,
    output logic  byte_valid_o,
    output byte_t byte_data_o,
    output logic  frame_start_o,
    output logic  frame_end_o,
    output logic  in_frame_o,
    output logic  frame_err_o
);

    typedef enum logic [1:0] {
        ps_hunt,
        ps_preamble,
        ps_data
    } parse_state_e;

    parse_state_e state_q;
    byte_t        rxd_q;
    logic         dv_q;
    logic         er_q;

    // pin register stage
    always_ff @(posedge gmii_rxc) begin
        rxd_q <= gmii_rxd_i;
        if (rst) begin
            dv_q <= 1'b0;
            er_q <= 1'b0;
        end else begin
            dv_q <= gmii_rx_dv_i;
            er_q <= gmii_rx_er_i;
        end
    end

    always_ff @(posedge gmii_rxc) begin
        byte_data_o <= rxd_q;
        if (rst) begin
            state_q       <= ps_hunt;
            byte_valid_o  <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            in_frame_o    <= 1'b0;
            frame_err_o   <= 1'b0;
        end else begin
            byte_valid_o  <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            if (frame_end_o) begin
                in_frame_o <= 1'b0;     // held through the end mark
            end
            case (state_q)
                ps_hunt: begin
                    if (dv_q && rxd_q == preamble_byte) begin
                        state_q     <= ps_preamble;
                        frame_err_o <= er_q;    // new frame, fresh error flag
                    end
                end
                ps_preamble: begin
                    frame_err_o <= frame_err_o | er_q;
                    if (!dv_q) begin
                        state_q <= ps_hunt;     // dv gap, start over
                    end else if (rxd_q == sfd_byte) begin
                        state_q    <= ps_data;
                        in_frame_o <= 1'b1;
                    end else if (rxd_q != preamble_byte) begin
                        state_q <= ps_hunt;
                    end
                end
                ps_data: begin
                    if (dv_q) begin
                        byte_valid_o  <= 1'b1;
                        frame_start_o <= !byte_valid_o;     // first byte after sfd
                        frame_err_o   <= frame_err_o | er_q;
                    end else begin
                        frame_end_o <= 1'b1;
                        state_q     <= ps_hunt;
                    end
                end
                default: state_q <= ps_hunt;
            endcase
        end
    end

endmodule

// File: hw/gmii_pkg.sv
package gmii_pkg;

    // one byte on the gmii data lines
    typedef logic [7:0] byte_t;

    // crc-32 register / fcs value
    typedef logic [31:0] crc_t;

    // line symbols ahead of the frame
    localparam byte_t preamble_byte = 8'h55;
    localparam byte_t sfd_byte      = 8'hD5;

    // ethernet crc-32, lsb first
    localparam crc_t crc_init    = 32'hFFFF_FFFF;
    localparam crc_t crc_poly    = 32'hEDB8_8320;   // reflected 0x04c11db7

    // register value once the fcs itself has been shifted through
    localparam crc_t crc_residue = 32'hDEBB_20E3;   // before final inversion

endpackage

// File: hw/rx_byte_counter.sv
`timescale 1ns/1ps

module rx_byte_counter import rx_pkg::*; (
    input  logic  gmii_rxc,
    input  logic  rst,
    input  logic  load_i,
    input  logic  inc_i,
    input  addr_t base_addr_i,
    output addr_t addr_o,
    output len_t  len_o
);

    addr_t addr_q;
    len_t  len_q;
    logic  has_data;

    assign has_data = (len_q != '0);    // first byte already written

    always_ff @(posedge gmii_rxc) begin
        if (rst) begin
            addr_q <= '0;
            len_q  <= '0;
        end else if (load_i) begin
            addr_q <= base_addr_i;
            len_q  <= '0;
        end else if (inc_i) begin
            if (has_data) begin
                addr_q <= addr_q + 16'd1;   // wraps
            end
            if (len_q != max_len) begin
                len_q <= len_q + 16'd1;
            end
        end
    end

    assign addr_o = addr_q;
    assign len_o  = len_q;

endmodule

// File: hw/rx_capture_fsm.sv
`timescale 1ns/1ps

module rx_capture_fsm
    import gmii_pkg::*;
    import rx_pkg::*;
(
    input  logic  gmii_rxc,
    input  logic  rst,
    input  logic  rx_ready_i,
    input  logic  in_frame_i,
    input  logic  frame_start_i,
    input  logic  frame_end_i,
    input  logic  frame_err_i,
    input  logic  byte_valid_i,
    input  byte_t byte_data_i,
    output logic  load_base_o,
    output logic  capture_en_o,
    output logic  rx_valid_o,
    output byte_t rx_data_o,
    output logic  rx_done_o,
    output logic  rx_err_o
);

    rx_state_e state_q;
    rx_state_e state_d;
    logic      done_latch;

    always_comb begin
        state_d     = state_q;
        load_base_o = 1'b0;
        done_latch  = 1'b0;
        case (state_q)
            st_idle: begin
                // a frame already on the line is let go by
                if (!rx_ready_i && !in_frame_i) begin
                    load_base_o = 1'b1;
                    state_d     = st_armed;
                end
            end
            st_armed: begin
                if (frame_start_i) begin
                    state_d = st_receive;
                end
            end
            st_receive: begin
                if (frame_end_i) begin
                    done_latch = 1'b1;
                    state_d    = st_done;
                end
            end
            st_done: begin
                if (rx_ready_i) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    // first byte arrives together with frame_start, still in st_armed
    assign capture_en_o = byte_valid_i &&
                          ((state_q == st_receive) || (state_q == st_armed && frame_start_i));

    assign rx_done_o = (state_q == st_done);

    always_ff @(posedge gmii_rxc) begin
        if (capture_en_o) begin
            rx_data_o <= byte_data_i;
        end
        if (rst) begin
            state_q    <= st_idle;
            rx_valid_o <= 1'b0;
            rx_err_o   <= 1'b0;
        end else begin
            state_q    <= state_d;
            rx_valid_o <= capture_en_o;
            if (load_base_o) begin
                rx_err_o <= 1'b0;
            end else if (done_latch) begin
                rx_err_o <= frame_err_i;    // sticky flag is final at frame_end
            end
        end
    end

endmodule

// File: hw/rx_crc32.sv
`timescale 1ns/1ps

module rx_crc32 import gmii_pkg::*; (
    input  logic  gmii_rxc,
    input  logic  rst,
    input  logic  init_i,
    input  logic  en_i,
    input  byte_t data_i,
    output logic  crc_ok_o
);

    crc_t crc_q;

    // one byte through the reflected crc, lsb first
    function automatic crc_t crc_byte(input crc_t crc, input byte_t d);
        crc_t c;
        c = crc ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge gmii_rxc) begin
        if (rst) begin
            crc_q <= crc_init;
        end else if (init_i) begin
            crc_q <= crc_init;
        end else if (en_i) begin
            crc_q <= crc_byte(crc_q, data_i);
        end
    end

    // fcs bytes go through too, so a clean frame lands on the residue
    assign crc_ok_o = (crc_q == crc_residue);

endmodule

// File: hw/rx_pkg.sv
package rx_pkg;

    // byte address into the user ram
    typedef logic [15:0] addr_t;

    // frame length in bytes, fcs included
    typedef logic [15:0] len_t;

    // length stops counting here
    localparam len_t max_len = 16'hFFFF;

    // capture side sequencing
    typedef enum logic [1:0] {
        st_idle,        // waiting for ready low and line quiet
        st_armed,       // base latched, waiting for first byte
        st_receive,     // bytes go out to the ram
        st_done         // results held until ready
    } rx_state_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# builds the GMII receive testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_eth_rx_top \
    -f eth_rx_top.f \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

exit 0

// File: testbench/eth_rx_checker.sv
`timescale 1ns/1ps

module eth_rx_checker import rx_pkg::*; (
    input logic gmii_rxc,
    input logic rst,
    input logic rx_ready_i,
    input logic rx_valid_i,
    input logic rx_done_i,
    input len_t rx_len_i
);

    // nothing goes to the ram while results are held
    no_write_while_done: assert property (
        @(posedge gmii_rxc) disable iff (rst)
        !(rx_valid_i && rx_done_i)
    ) else $error("rx_valid_o high while rx_done_o is held");

    // done is released by the user only
    done_needs_ready: assert property (
        @(posedge gmii_rxc) disable iff (rst)
        $fell(rx_done_i) |-> $past(rx_ready_i)
    ) else $error("rx_done_o fell without rx_ready_i high");

    len_held: assert property (
        @(posedge gmii_rxc) disable iff (rst)
        (rx_done_i && $past(rx_done_i)) |-> $stable(rx_len_i)
    ) else $error("rx_len_o changed while rx_done_o is held");

endmodule

// File: testbench/eth_rx_vectors.txt
// first word: number of lines; then per line, hex:
// len seed preamble base err_at(FFFF none) bad_fcs ready_delay busy(1 held, 2 skipped)
0008
0040 0011 0007 0100 FFFF 0000 0003 0000
002E 0022 0001 1000 FFFF 0000 0002 0000
0080 0033 0007 FFF0 FFFF 0000 0004 0000
0030 0044 0007 0200 FFFF 0001 0002 0000
0035 0055 0007 0300 0010 0000 0002 0000
0020 0066 0007 0400 FFFF 0000 0014 0001
0028 0077 0003 0500 FFFF 0000 0002 0002
0100 0088 0007 0600 FFFF 0000 0001 0000

// File: testbench/tb_eth_rx_top.sv
`timescale 1ns/1ps

module tb_eth_rx_top import gmii_pkg::*, rx_pkg::*; ();

    localparam int clk_period   = 40;
    localparam int tb_seed      = 32'h9df8;
    localparam int vec_words    = 65;     // count plus 8 lines of 8 fields
    localparam int gap_cycles   = 12;
    localparam int done_timeout = 400;

    logic  gmii_rxc;
    logic  rst;
    byte_t gmii_rxd;
    logic  gmii_rx_dv;
    logic  gmii_rx_er;
    addr_t rx_addr;
    logic  rx_ready;
    byte_t rx_data_o;
    addr_t rx_addr_o;
    logic  rx_valid_o;
    len_t  rx_len_o;
    logic  rx_crc_ok_o;
    logic  rx_err_o;
    logic  rx_done_o;

    logic [15:0] vec_mem [0:vec_words-1];
    byte_t tx_q[$];
    byte_t exp_q[$];
    addr_t exp_base;
    addr_t exp_addr;
    logic  expect_writes;
    int    wr_idx;
    int    errors;
    int    checks;
    int    wd_cycles;

    eth_rx_top u_eth_rx_top (
        .gmii_rxc     (gmii_rxc),
        .rst          (rst),
        .gmii_rxd_i   (gmii_rxd),
        .gmii_rx_dv_i (gmii_rx_dv),
        .gmii_rx_er_i (gmii_rx_er),
        .rx_addr_i    (rx_addr),
        .rx_ready_i   (rx_ready),
        .rx_data_o    (rx_data_o),
        .rx_addr_o    (rx_addr_o),
        .rx_valid_o   (rx_valid_o),
        .rx_len_o     (rx_len_o),
        .rx_crc_ok_o  (rx_crc_ok_o),
        .rx_err_o     (rx_err_o),
        .rx_done_o    (rx_done_o)
    );

    bind eth_rx_top eth_rx_checker u_checker (
        .gmii_rxc   (gmii_rxc),
        .rst        (rst),
        .rx_ready_i (rx_ready_i),
        .rx_valid_i (rx_valid_o),
        .rx_done_i  (rx_done_o),
        .rx_len_i   (rx_len_o)
    );

    initial begin
        gmii_rxc = 1'b0;
        forever #(clk_period / 2) gmii_rxc = ~gmii_rxc;
    end

    task automatic check_eq(input string name, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // ram side writes, compared byte by byte
    always @(negedge gmii_rxc) begin
        if (!rst && rx_valid_o) begin
            checks++;
            assert (expect_writes && wr_idx < exp_q.size()) else begin
                errors++;
                $display("write at %0t ns that should not happen (dropped or extra byte)",
                         $time);
            end
            if (expect_writes && wr_idx < exp_q.size()) begin
                exp_addr = exp_base + addr_t'(wr_idx);   // wraps like the ram address
                check_eq("rx_data_o", int'(exp_q[wr_idx]), int'(rx_data_o));
                check_eq("rx_addr_o", int'(exp_addr), int'(rx_addr_o));
            end
            wr_idx++;
        end
    end

    task automatic drive_line(input logic dv, input byte_t d, input logic er);
        @(posedge gmii_rxc);
        #5;
        gmii_rx_dv = dv;
        gmii_rxd   = d;
        gmii_rx_er = er;
    endtask

    // payload from the shared random stream, then the fcs lsb first
    task automatic build_frame(input int len, input int seed, input bit bad_fcs);
        crc_t c;
        logic fb;
        tx_q.delete();
        for (int i = 0; i < len; i++) begin
            tx_q.push_back(byte_t'($urandom() ^ seed));
        end
        c = crc_init;
        foreach (tx_q[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ tx_q[i][b];
                c  = c >> 1;
                if (fb) begin
                    c = c ^ crc_poly;
                end
            end
        end
        c = ~c;
        for (int k = 0; k < 4; k++) begin
            tx_q.push_back(c[8*k +: 8]);
        end
        if (bad_fcs) begin
            tx_q[len] = tx_q[len] ^ 8'h01;
        end
    endtask

    task automatic send_frame(input int pre, input int err_at, input int ready_low_at);
        for (int i = 0; i < pre; i++) begin
            drive_line(1'b1, preamble_byte, 1'b0);
        end
        drive_line(1'b1, sfd_byte, 1'b0);
        for (int i = 0; i < tx_q.size(); i++) begin
            drive_line(1'b1, tx_q[i], 1'(i == err_at));
            if (i == ready_low_at) begin
                rx_ready = 1'b0;    // user re-arms with this frame on the line
            end
        end
        for (int i = 0; i < gap_cycles; i++) begin
            drive_line(1'b0, 8'h00, 1'b0);
        end
    endtask

    task automatic wait_done(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < done_timeout; i++) begin
            @(negedge gmii_rxc);
            if (rx_done_o) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic run_vector(input int v);
        int    len;
        int    seed;
        int    pre;
        int    err_at;
        int    rdy_dly;
        int    busy;
        bit    bad_fcs;
        bit    ok;
        addr_t base;
        len     = int'(vec_mem[1 + v*8]);
        seed    = int'(vec_mem[2 + v*8]);
        pre     = int'(vec_mem[3 + v*8]);
        base    = vec_mem[4 + v*8];
        err_at  = (vec_mem[5 + v*8] == 16'hFFFF) ? -1 : int'(vec_mem[5 + v*8]);
        bad_fcs = (vec_mem[6 + v*8] != 16'h0);
        rdy_dly = int'(vec_mem[7 + v*8]);
        busy    = int'(vec_mem[8 + v*8]);
        build_frame(len, seed, bad_fcs);
        expect_writes = 1'b0;
        @(posedge gmii_rxc);
        #5;
        rx_addr       = base;
        if (busy == 2) begin
            send_frame(7, -1, 3);   // ready drops mid frame, frame must be skipped
        end
        exp_q    = tx_q;
        exp_base = base;
        wr_idx   = 0;
        @(posedge gmii_rxc);
        #5;
        rx_ready = 1'b0;
        repeat (3) @(posedge gmii_rxc);
        expect_writes = 1'b1;
        send_frame(pre, err_at, -1);
        wait_done(ok);
        checks++;
        assert (ok) else begin
            errors++;
            $display("rx_done_o never rose for vector %0d", v);
        end
        expect_writes = 1'b0;
        check_eq("byte count", len + 4, wr_idx);
        check_eq("rx_len_o", len + 4, int'(rx_len_o));
        check_eq("rx_crc_ok_o", int'(!bad_fcs), int'(rx_crc_ok_o));
        check_eq("rx_err_o", int'(err_at >= 0), int'(rx_err_o));
        if (busy == 1) begin
            send_frame(pre, -1, -1);    // arrives while done is held
            @(negedge gmii_rxc);
            check_eq("rx_done_o", 1, int'(rx_done_o));
        end
        for (int i = 0; i < rdy_dly; i++) begin
            @(negedge gmii_rxc);
            check_eq("rx_done_o", 1, int'(rx_done_o));
        end
        @(posedge gmii_rxc);
        #5;
        rx_ready = 1'b1;
        repeat (3) @(negedge gmii_rxc);
        check_eq("rx_done_o", 0, int'(rx_done_o));
    endtask

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge gmii_rxc);
        $display("timeout: the run did not finish in the expected time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int n_vec;
        int budget;
        void'($urandom(tb_seed));
        rst           = 1'b1;
        gmii_rxd      = 8'h00;
        gmii_rx_dv    = 1'b0;
        gmii_rx_er    = 1'b0;
        rx_addr       = '0;
        rx_ready      = 1'b1;
        expect_writes = 1'b0;
        wr_idx        = 0;
        errors        = 0;
        checks        = 0;
        wd_cycles     = 0;
        $readmemh("testbench/eth_rx_vectors.txt", vec_mem);
        n_vec  = int'(vec_mem[0]);
        budget = 100;
        for (int v = 0; v < n_vec; v++) begin
            // main frame plus a possible dropped one, gaps and handshake
            budget += 2 * (int'(vec_mem[1 + v*8]) + 13) + 2 * gap_cycles;
            budget += int'(vec_mem[7 + v*8]) + 20;
        end
        wd_cycles = budget;
        repeat (10) @(posedge gmii_rxc);
        #5;
        rst = 1'b0;
        @(negedge gmii_rxc);
        check_eq("rx_done_o", 0, int'(rx_done_o));
        check_eq("rx_valid_o", 0, int'(rx_valid_o));
        for (int v = 0; v < n_vec; v++) begin
            run_vector(v);
        end
        repeat (10) @(posedge gmii_rxc);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
